// File: verilog/cim_aes_pkg.sv
// shared types, constants and group address tables of the CIM AES-128 controller
package cim_aes_pkg;

    // ----------------------------------------
    // data widths
    // ----------------------------------------
    typedef logic [127:0] block_t;
    typedef logic [7:0]   byte_t;
    typedef logic [2:0]   demux_t;
    typedef logic [5:0]   row_t;
    typedef logic [15:0]  stream_t;
    typedef logic [3:0]   group_t;
    typedef logic [2:0]   beat_t;

    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_READ   = 2'd1,
        PH_LOOKUP = 2'd2,
        PH_OUT    = 2'd3
    } phase_t;

    // ----------------------------------------
    // sequencing constants
    // ----------------------------------------
    localparam int NUM_GROUPS = 11;
    localparam int NUM_BEATS  = 8;
    localparam int NUM_LANES  = 16;
    localparam group_t LAST_GROUP = group_t'(NUM_GROUPS - 1);

    // column demux of the round-key region for each group
    function automatic demux_t group_demux(input group_t g);
        case (g)
            4'd0, 4'd4, 4'd8:  return 3'd7;
            4'd1, 4'd5, 4'd9:  return 3'd6;
            4'd2, 4'd6, 4'd10: return 3'd5;
            4'd3, 4'd7:        return 3'd4;
            default:           return 3'd0;
        endcase
    endfunction

    // four groups share one word line
    function automatic row_t group_row(input group_t g);
        return row_t'(g >> 2);
    endfunction

endpackage

// File: verilog/cim_ctrl_if.sv
// control bundle from the group sequencer to the array port and the state datapath
`timescale 1ns/1ps

interface cim_ctrl_if import cim_aes_pkg::*; ();

    // registered sequencer state
    phase_t phase;
    group_t group;
    beat_t  beat;

    // accepted start, one enabled cycle
    logic   load;

    // high for the single PH_OUT cycle
    logic   done;

    modport seq (
        output phase,
        output group,
        output beat,
        output load,
        output done
    );

    modport data (
        input  phase,
        input  group,
        input  beat,
        input  load,
        input  done
    );

endinterface

// File: verilog/aes_mix_core.sv
// AES ShiftRows with optional MixColumns on one 128-bit state
`timescale 1ns/1ps

module aes_mix_core import cim_aes_pkg::*; (
    input  block_t state_in,
    input  logic   with_mix,
    output block_t state_out
);

    block_t shifted;

    // byte 4c+r sits at bits 127-8(4c+r), row r and column c
    function automatic byte_t get_byte(input block_t s, input int idx);
        return s[127 - 8 * idx -: 8];
    endfunction

    // multiply by x in GF(2^8)
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic block_t shift_rows(input block_t s);
        block_t t;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                t[127 - 8 * (4 * c + r) -: 8] = get_byte(s, 4 * ((c + r) % 4) + r);
            end
        end
        return t;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t t;
        byte_t  a0;
        byte_t  a1;
        byte_t  a2;
        byte_t  a3;
        for (int c = 0; c < 4; c++) begin
            a0 = get_byte(s, 4 * c);
            a1 = get_byte(s, 4 * c + 1);
            a2 = get_byte(s, 4 * c + 2);
            a3 = get_byte(s, 4 * c + 3);
            // 2 3 1 1 circulant
            t[127 - 32 * c -: 8]  = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            t[119 - 32 * c -: 8]  = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            t[111 - 32 * c -: 8]  = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            t[103 - 32 * c -: 8]  = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return t;
    endfunction

    assign shifted   = shift_rows(state_in);
    assign state_out = with_mix ? mix_columns(shifted) : shifted;

endmodule

// File: verilog/group_sequencer.sv
// group sequencer that steps 11 read/lookup groups and raises the status flags
`timescale 1ns/1ps

module group_sequencer import cim_aes_pkg::*; (
    input  logic CLK,
    input  logic rst,
    input  logic en,
    input  logic start,
    cim_ctrl_if.seq ctrl,
    output logic kvld,
    output logic dvld,
    output logic busy
);

    phase_t state_q;
    group_t group_q;
    beat_t  beat_q;
    logic   accept;

    // start only counts in idle
    assign accept = en && start && (state_q == PH_IDLE);

    assign ctrl.phase = state_q;
    assign ctrl.group = group_q;
    assign ctrl.beat  = beat_q;
    assign ctrl.load  = accept;
    assign ctrl.done  = (state_q == PH_OUT);

    // ----------------------------------------
    // phase FSM with group and beat counters
    // ----------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state_q <= PH_IDLE;
            group_q <= '0;
            beat_q  <= '0;
        end else if (en) begin
            case (state_q)
                PH_IDLE: begin
                    if (accept) begin
                        state_q <= PH_READ;
                        group_q <= '0;
                        beat_q  <= '0;
                    end
                end
                PH_READ: begin
                    if (beat_q == beat_t'(NUM_BEATS - 1)) begin
                        beat_q  <= '0;
                        state_q <= PH_LOOKUP;
                    end else begin
                        beat_q <= beat_q + beat_t'(1);
                    end
                end
                PH_LOOKUP: begin
                    if (group_q == LAST_GROUP) begin
                        state_q <= PH_OUT;
                    end else begin
                        group_q <= group_q + group_t'(1);
                        state_q <= PH_READ;
                    end
                end
                PH_OUT: begin
                    state_q <= PH_IDLE;
                end
                default: begin
                    state_q <= PH_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // status flags
    // ----------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            kvld <= 1'b0;
            dvld <= 1'b0;
            busy <= 1'b0;
        end else if (en) begin
            // one-cycle pulses
            kvld <= accept;
            dvld <= (state_q == PH_OUT);
            if (accept) begin
                busy <= 1'b1;
            end else if (state_q == PH_OUT) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/cim_array_port.sv
// array port that drives the CIM addresses and IN stream and captures RIO planes and bytes
`timescale 1ns/1ps

module cim_array_port import cim_aes_pkg::*; (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    en,
    cim_ctrl_if.data                ctrl,
    input  block_t                  next_src,
    input  block_t                  rio,
    output demux_t [NUM_LANES-1:0]  demux_addr,
    output row_t   [NUM_LANES-1:0]  rwl_addr,
    output stream_t                 in_word,
    output block_t                  captured
);

    // bit planes of the AddRoundKey result, two entries per read beat
    byte_t plane [NUM_LANES];

    byte_t plane_lo;
    byte_t plane_hi;
    int    slice_lsb;

    // bit 7-beat of every lane, lane 0 and lane 8 at the LSB
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            plane_lo[i] = rio[8 * i + 7 - int'(ctrl.beat)];
            plane_hi[i] = rio[8 * (i + 8) + 7 - int'(ctrl.beat)];
        end
    end

    // MSB-first 16-bit slices
    assign slice_lsb = 16 * (NUM_BEATS - 1 - int'(ctrl.beat));

    // ----------------------------------------
    // address and stream outputs
    // ----------------------------------------
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            demux_addr <= '0;
            rwl_addr   <= '0;
            in_word    <= '0;
        end else if (en) begin
            case (ctrl.phase)
                PH_READ: begin
                    // every lane reads the same round-key cell
                    for (int j = 0; j < NUM_LANES; j++) begin
                        demux_addr[j] <= group_demux(ctrl.group);
                        rwl_addr[j]   <= group_row(ctrl.group);
                    end
                    in_word <= next_src[slice_lsb +: 16];
                end
                PH_LOOKUP: begin
                    // sbox lookup address straight from the plane byte
                    for (int j = 0; j < NUM_LANES; j++) begin
                        demux_addr[j] <= {1'b0, plane[j][7:6]};
                        rwl_addr[j]   <= plane[j][5:0];
                    end
                    in_word <= '0;
                end
                default: begin
                    in_word <= '0;
                end
            endcase
        end
    end

    // ----------------------------------------
    // plane and lookup capture
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (en) begin
            if (ctrl.phase == PH_READ) begin
                plane[{ctrl.beat, 1'b0}] <= plane_lo;
                plane[{ctrl.beat, 1'b1}] <= plane_hi;
            end
            if (ctrl.phase == PH_LOOKUP) begin
                captured <= rio;
            end
        end
    end

endmodule

// File: verilog/state_datapath.sv
// state datapath holding plaintext and key, selecting the stream source and loading dout
`timescale 1ns/1ps

module state_datapath import cim_aes_pkg::*; (
    input  logic     CLK,
    input  logic     rst,
    input  logic     en,
    cim_ctrl_if.data ctrl,
    input  block_t   din,
    input  block_t   kin,
    input  block_t   captured,
    output block_t   next_src,
    output block_t   dout
);

    block_t din_q;
    block_t key_q;
    block_t mixed;
    block_t shifted;

    // full round for the middle groups
    aes_mix_core u_mix (
        .state_in  (captured),
        .with_mix  (1'b1),
        .state_out (mixed)
    );

    // last round skips MixColumns
    aes_mix_core u_shift (
        .state_in  (captured),
        .with_mix  (1'b0),
        .state_out (shifted)
    );

    always_ff @(posedge CLK) begin
        if (en && ctrl.load) begin
            din_q <= din;
            key_q <= kin;
        end
    end

    // group 0 streams the plaintext for the first AddRoundKey
    assign next_src = (ctrl.group == '0) ? din_q : mixed;

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (en && ctrl.done) begin
            dout <= shifted ^ key_q;
        end
    end

endmodule

// File: verilog/cim_aes_top.sv
// top level of the CIM AES-128 controller, sequencer, array port and state datapath
`timescale 1ns/1ps

module cim_aes_top import cim_aes_pkg::*; (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    start,
    input  block_t                  din,
    input  block_t                  kin,
    input  block_t                  rio,
    output demux_t [NUM_LANES-1:0]  demux_addr,
    output row_t   [NUM_LANES-1:0]  rwl_addr,
    output stream_t                 in_word,
    output block_t                  dout,
    output logic                    kvld,
    output logic                    dvld,
    output logic                    busy
);

    block_t next_src;
    block_t captured;

    cim_ctrl_if ctrl ();

    group_sequencer u_seq (
        .CLK   (CLK),
        .rst   (rst),
        .en    (en),
        .start (start),
        .ctrl  (ctrl.seq),
        .kvld  (kvld),
        .dvld  (dvld),
        .busy  (busy)
    );

    cim_array_port u_port (
        .CLK        (CLK),
        .rst        (rst),
        .en         (en),
        .ctrl       (ctrl.data),
        .next_src   (next_src),
        .rio        (rio),
        .demux_addr (demux_addr),
        .rwl_addr   (rwl_addr),
        .in_word    (in_word),
        .captured   (captured)
    );

    state_datapath u_dp (
        .CLK      (CLK),
        .rst      (rst),
        .en       (en),
        .ctrl     (ctrl.data),
        .din      (din),
        .kin      (kin),
        .captured (captured),
        .next_src (next_src),
        .dout     (dout)
    );

endmodule

// File: verification/cim_aes_chk.sv
// protocol checker for the CIM AES-128 top level, bound onto its ports
`timescale 1ns/1ps

module cim_aes_chk import cim_aes_pkg::*; (
    input logic                   CLK,
    input logic                   rst,
    input logic                   en,
    input logic                   start,
    input demux_t [NUM_LANES-1:0] demux_addr,
    input row_t   [NUM_LANES-1:0] rwl_addr,
    input stream_t                in_word,
    input block_t                 dout,
    input logic                   kvld,
    input logic                   dvld,
    input logic                   busy
);

    int err_count = 0;

    task automatic flag(input string msg);
        err_count++;
        $error("ERR %0t %s", $time, msg);
    endtask

    // ----------------------------------------
    // reset, pulses and busy window
    // ----------------------------------------
    a_reset_clear: assert property (@(posedge CLK) rst |=> !kvld && !dvld && !busy
        && demux_addr == '0 && rwl_addr == '0 && in_word == '0 && dout == '0)
        else flag("outputs not clear in reset");
    a_kvld_pulse: assert property (@(posedge CLK) disable iff (rst) en && kvld |=> !kvld)
        else flag("kvld longer than one enabled cycle");
    a_dvld_pulse: assert property (@(posedge CLK) disable iff (rst) en && dvld |=> !dvld)
        else flag("dvld longer than one enabled cycle");
    a_kvld_busy: assert property (@(posedge CLK) disable iff (rst) kvld |-> busy)
        else flag("kvld without busy");
    a_busy_fall: assert property (@(posedge CLK) disable iff (rst) $fell(busy) |-> dvld)
        else flag("busy fell without dvld");

    // start while busy must not restart the sequence
    a_start_ignored: assert property (@(posedge CLK) disable iff (rst)
        en && start && busy |=> !kvld)
        else flag("start accepted while busy");

    // en low freezes every output
    a_hold: assert property (@(posedge CLK) disable iff (rst) !en |=> $stable(kvld)
        && $stable(dvld) && $stable(busy) && $stable(dout) && $stable(in_word)
        && $stable(demux_addr) && $stable(rwl_addr))
        else flag("outputs moved while en was low");

endmodule

bind cim_aes_top cim_aes_chk chk0 (.*);

// File: verification/cim_aes_tb.sv
// testbench for the CIM AES-128 controller with a behavioral array and reference model
`timescale 1ns/1ps

module cim_aes_tb import cim_aes_pkg::*; ();

    logic                   CLK = 1'b0;
    logic                   rst = 1'b1;
    logic                   en = 1'b0;
    logic                   start = 1'b0;
    block_t                 din = '0;
    block_t                 kin = '0;
    block_t                 rio = '0;
    demux_t [NUM_LANES-1:0] demux_addr;
    row_t   [NUM_LANES-1:0] rwl_addr;
    stream_t                in_word;
    block_t                 dout;
    logic                   kvld;
    logic                   dvld;
    logic                   busy;
    int                     edges = 0;

    cim_aes_top dut0 (.*);

    always #50 CLK = ~CLK;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input bit ok, input string what);
        assert (ok) else stop_run($sformatf("ERR %0t %s", $time, what));
    endtask

    always @(dut0.chk0.err_count) begin
        if (dut0.chk0.err_count != 0)
            stop_run("an assertion bound to the DUT ports failed");
    end

    function automatic block_t rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic byte_t times_two(input byte_t a);
        return (a << 1) ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // ----------------------------------------
    // reference round, byte 0 at the block MSB
    // ----------------------------------------
    function automatic block_t ref_round(input block_t s, input bit mix);
        byte_t  t [16];
        block_t res;
        int     n1;
        int     n2;
        int     n3;
        for (int i = 0; i < 16; i++) begin
            // row i%4 rotates left by its own index
            t[i] = s[127 - 8 * ((i + 4 * (i % 4)) % 16) -: 8];
        end
        for (int i = 0; i < 16; i++) begin
            n1 = i - i % 4 + (i + 1) % 4;
            n2 = i - i % 4 + (i + 2) % 4;
            n3 = i - i % 4 + (i + 3) % 4;
            res[127 - 8 * i -: 8] = mix ? times_two(t[i] ^ t[n1]) ^ t[n1] ^ t[n2] ^ t[n3] : t[i];
        end
        return res;
    endfunction

    // one enabled edge with rio held, sometimes after a few cycles with en low
    task automatic step(input block_t rio_val, input bit stall);
        int idle_n;
        idle_n = stall ? $urandom_range(2) : 0;
        repeat (idle_n) begin
            en = 1'b0;
            rio = rand_block();
            @(negedge CLK);
        end
        en = 1'b1;
        rio = rio_val;
        start = $urandom_range(1);
        @(posedge CLK);
        edges++;
        @(negedge CLK);
    endtask

    task automatic encrypt(input bit stall);
        block_t din_v;
        block_t key_v;
        block_t src;
        block_t cap;
        block_t rv [NUM_BEATS];
        byte_t  pl;
        int     wait_n;
        din_v = rand_block();
        key_v = rand_block();
        din = din_v;
        kin = key_v;
        start = 1'b1;
        en = 1'b1;
        @(posedge CLK);
        edges = 0;
        @(negedge CLK);
        check_value(kvld && busy, $sformatf("kvld %b busy %b after start", kvld, busy));
        din = rand_block();
        kin = rand_block();
        src = din_v;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int b = 0; b < NUM_BEATS; b++) begin
                rv[b] = rand_block();
                step(rv[b], stall);
                check_value(busy && !dvld && in_word == src[127 - 16 * b -: 16],
                    $sformatf("in_word %h in group %0d beat %0d", in_word, g, b));
                check_value(demux_addr == {NUM_LANES{demux_t'(7 - g % 4)}}
                    && rwl_addr == {NUM_LANES{row_t'(g / 4)}},
                    $sformatf("read address in group %0d beat %0d", g, b));
            end
            cap = rand_block();
            step(cap, stall);
            for (int j = 0; j < NUM_LANES; j++) begin
                // plane j from bit 7-j/2 of lanes 0..7 or 8..15
                for (int k = 0; k < 8; k++) begin
                    pl[k] = rv[j / 2][8 * (k + 8 * (j % 2)) + 7 - j / 2];
                end
                check_value(in_word == '0 && demux_addr[j] == {1'b0, pl[7:6]}
                    && rwl_addr[j] == pl[5:0], $sformatf("lookup address of lane %0d", j));
            end
            src = ref_round(cap, 1'b1);
        end
        wait_n = 0;
        while (!dvld) begin
            step(rand_block(), stall);
            wait_n++;
            if (wait_n > 20)
                stop_run("timeout while waiting for dvld");
        end
        start = 1'b0;
        check_value(edges == 100, $sformatf("dvld after %0d enabled edges", edges));
        check_value(!busy, "busy still high with dvld");
        check_value(dout == (ref_round(cap, 1'b0) ^ key_v), $sformatf("dout %h", dout));
    endtask

    initial begin
        void'($urandom(32'hce9466c4));
        repeat (10) @(negedge CLK);
        rst = 1'b0;
        @(negedge CLK);
        check_value(!kvld && !dvld && !busy && demux_addr == '0 && rwl_addr == '0,
            "outputs not clear after reset");
        encrypt(1'b0);
        encrypt(1'b1);
        encrypt(1'b0);
        if (dut0.chk0.err_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_run("bound assertions reported failures");
        end
    end

endmodule

// File: sim.f
verilog/cim_aes_pkg.sv
verilog/cim_ctrl_if.sv
verilog/aes_mix_core.sv
verilog/group_sequencer.sv
verilog/cim_array_port.sv
verilog/state_datapath.sv
verilog/cim_aes_top.sv
verification/cim_aes_chk.sv
verification/cim_aes_tb.sv
